// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_lane_sequencer
FILELIST  ?= lane_sequencer.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= *** PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -F '$(PASS_MSG)' > /dev/null

clean:
	rm -rf $(OBJ_DIR)

// File: bench/tb_lane_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module tb_lane_sequencer;

  localparam int unsigned N_ENTRIES       = 12;
  localparam int unsigned RESET_CYCLES    = 10;
  localparam int unsigned RAND_CYCLES     = 40;
  localparam int unsigned WATCHDOG_CYCLES = RESET_CYCLES + N_ENTRIES * 50 + RAND_CYCLES;
  localparam logic [15:0] LFSR_SEED       = 16'd47192;

  // One row of the stimulus table
  // A set blk marks a request that must wait
  typedef struct packed {
    lane_seq_pkg::lane_id_t lane;
    lane_seq_pkg::vid_t     id;
    logic                   vfu;
    logic                   vm;
    logic                   swap;
    logic                   use_vs1;
    logic                   use_vs2;
    logic                   use_vd;
    logic [1:0]             sew;
    lane_seq_pkg::vlen_t    vl;
    lane_seq_pkg::vlen_t    vstart;
    logic [3:0]             hold_rdy;
    logic [3:0]             hold_run;
    logic                   blk;
  } entry_t;

  logic                                                  clk;
  logic                                                  rst_n;
  lane_seq_pkg::lane_id_t                                lane_id;
  lane_seq_pkg::pe_req_t                                 pe_req;
  logic                                                  pe_req_valid;
  logic                                                  pe_req_ready;
  lane_seq_pkg::vinsn_mask_t                             running;
  lane_seq_pkg::vinsn_mask_t                             done_o;
  lane_seq_pkg::operand_cmd_t [lane_seq_pkg::NR_OPQ-1:0] operand_cmd;
  logic [lane_seq_pkg::NR_OPQ-1:0]                       cmd_valid;
  logic [lane_seq_pkg::NR_OPQ-1:0]                       operand_ready;
  lane_seq_pkg::vfu_op_t                                 vfu_op;
  logic                                                  vfu_op_valid;
  lane_seq_pkg::vinsn_mask_t                             alu_vinsn_done;
  lane_seq_pkg::vinsn_mask_t                             mfpu_vinsn_done;
  logic                                                  alu_done;
  logic                                                  mfpu_done;

  entry_t      tbl [N_ENTRIES];
  int          rdy_left;
  int          run_left;
  logic [15:0] lfsr;

  lane_sequencer dut0 (
    .clk_i               (clk),
    .rst_ni              (rst_n),
    .lane_id_i           (lane_id),
    .pe_req_i            (pe_req),
    .pe_req_valid_i      (pe_req_valid),
    .pe_req_ready_o      (pe_req_ready),
    .pe_vinsn_running_i  (running),
    .pe_vinsn_done_o     (done_o),
    .operand_cmd_o       (operand_cmd),
    .operand_cmd_valid_o (cmd_valid),
    .operand_cmd_ready_i (operand_ready),
    .vfu_op_o            (vfu_op),
    .vfu_op_valid_o      (vfu_op_valid),
    .alu_vinsn_done_i    (alu_vinsn_done),
    .mfpu_vinsn_done_i   (mfpu_vinsn_done),
    .alu_done_o          (alu_done),
    .mfpu_done_o         (mfpu_done)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////
  // Checking helpers
  ////////////////////////////////////////

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("FAIL time=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, want);
    $display("*** FAILED ***");
    $fatal(1, "Stopping on the first mismatch");
  endtask

  task automatic expect_eq(input string name, input logic [31:0] got,
                           input logic [31:0] want);
    assert (got == want) else report_mismatch(name, got, want);
  endtask

  // Reference lengths follow the element split rules of the lane
  function automatic int exp_lane_vl(input int vl, input int lane);
    return vl / 4 + ((lane < vl % 4) ? 1 : 0);
  endfunction

  function automatic int exp_lane_vstart(input int vstart, input int lane);
    return vstart / 4 - ((lane < vstart % 4) ? 1 : 0);
  endfunction

  function automatic int exp_mask_vl(input int vl, input int sew);
    int words;
    words = (vl / 32) >> sew;
    if (((words << sew) * 32) != vl) begin
      words = words + 1;
    end
    return words;
  endfunction

  // Fibonacci LFSR with taps 16, 14, 13 and 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_mask(output lane_seq_pkg::vinsn_mask_t m);
    for (int b = 0; b < lane_seq_pkg::NR_VINSN; b++) begin
      lfsr = lfsr_step(lfsr);
      m[b] = lfsr[0];
    end
  endtask

  function automatic entry_t make_entry(
    input lane_seq_pkg::lane_id_t lane, input lane_seq_pkg::vid_t id, input logic vfu,
    input logic vm, input logic swap, input logic use_vs1, input logic use_vs2,
    input logic use_vd, input logic [1:0] sew, input lane_seq_pkg::vlen_t vl,
    input lane_seq_pkg::vlen_t vstart, input logic [3:0] hold_rdy,
    input logic [3:0] hold_run, input logic blk
  );
    return '{lane, id, vfu, vm, swap, use_vs1, use_vs2, use_vd, sew, vl, vstart,
             hold_rdy, hold_run, blk};
  endfunction

  function automatic lane_seq_pkg::pe_req_t build_req(input int i, input entry_t e);
    lane_seq_pkg::pe_req_t r;
    r.id          = e.id;
    r.op          = lane_seq_pkg::vop_t'(i);
    r.vfu         = lane_seq_pkg::vfu_e'(e.vfu);
    r.vm          = e.vm;
    r.vs1         = lane_seq_pkg::vreg_t'(i + 1);
    r.vs2         = lane_seq_pkg::vreg_t'(i + 8);
    r.vd          = lane_seq_pkg::vreg_t'(i + 16);
    r.use_vs1     = e.use_vs1;
    r.use_vs2     = e.use_vs2;
    r.use_vd_op   = e.use_vd;
    r.swap_vs2_vd = e.swap;
    r.sew         = lane_seq_pkg::sew_e'(e.sew);
    r.vl          = e.vl;
    r.vstart      = e.vstart;
    return r;
  endfunction

  // Advance to the next falling edge and update the operand reader and running models
  task automatic step();
    @(negedge clk);
    if (rdy_left > 0) begin
      rdy_left--;
    end
    if (run_left > 0) begin
      run_left--;
    end
    operand_ready = (rdy_left == 0) ? '1 : '0;
    if (run_left == 0) begin
      running = '0;
    end
  endtask

  task automatic check_cmd(input int q, input int id, input int vs, input int eew,
                           input int vl, input int vstart);
    expect_eq($sformatf("operand_cmd_o[%0d].id", q), 32'(operand_cmd[q].id), id);
    expect_eq($sformatf("operand_cmd_o[%0d].vs", q), 32'(operand_cmd[q].vs), vs);
    expect_eq($sformatf("operand_cmd_o[%0d].eew", q), 32'(operand_cmd[q].eew), eew);
    expect_eq($sformatf("operand_cmd_o[%0d].vl", q), 32'(operand_cmd[q].vl), vl);
    expect_eq($sformatf("operand_cmd_o[%0d].vstart", q), 32'(operand_cmd[q].vstart),
              32'(vstart) & 32'hffff);
  endtask

  task automatic check_issue(input int i, input entry_t e);
    int                              lvl;
    int                              lvs;
    int                              vs_exp [lane_seq_pkg::NR_OPQ];
    logic [lane_seq_pkg::NR_OPQ-1:0] push;
    lvl = exp_lane_vl(int'(e.vl), int'(e.lane));
    lvs = exp_lane_vstart(int'(e.vstart), int'(e.lane));
    expect_eq("vfu_op_valid_o", 32'(vfu_op_valid), 1);
    expect_eq("vfu_op_o.id", 32'(vfu_op.id), 32'(e.id));
    expect_eq("vfu_op_o.op", 32'(vfu_op.op), i);
    expect_eq("vfu_op_o.vfu", 32'(vfu_op.vfu), 32'(e.vfu));
    expect_eq("vfu_op_o.vm", 32'(vfu_op.vm), 32'(e.vm));
    expect_eq("vfu_op_o.vd", 32'(vfu_op.vd), i + 16);
    expect_eq("vfu_op_o.sew", 32'(vfu_op.sew), 32'(e.sew));
    expect_eq("vfu_op_o.vl", 32'(vfu_op.vl), lvl);
    expect_eq("vfu_op_o.vstart", 32'(vfu_op.vstart), 32'(lvs) & 32'hffff);

    // Swapped multiply-add forms read vd through B and vs2 through C
    push = '0;
    push[lane_seq_pkg::MASK_M] = !e.vm;
    if (!e.vfu) begin
      push[lane_seq_pkg::ALU_A] = e.use_vs1;
      push[lane_seq_pkg::ALU_B] = e.use_vs2;
    end else begin
      push[lane_seq_pkg::MFPU_A] = e.use_vs1;
      push[lane_seq_pkg::MFPU_B] = e.swap ? e.use_vd : e.use_vs2;
      push[lane_seq_pkg::MFPU_C] = e.swap ? e.use_vs2 : e.use_vd;
    end
    vs_exp[lane_seq_pkg::ALU_A]  = i + 1;
    vs_exp[lane_seq_pkg::ALU_B]  = i + 8;
    vs_exp[lane_seq_pkg::MFPU_A] = i + 1;
    vs_exp[lane_seq_pkg::MFPU_B] = e.swap ? i + 16 : i + 8;
    vs_exp[lane_seq_pkg::MFPU_C] = e.swap ? i + 8 : i + 16;
    vs_exp[lane_seq_pkg::MASK_M] = 0;

    expect_eq("operand_cmd_valid_o", 32'(cmd_valid), 32'(push));
    for (int q = 0; q < lane_seq_pkg::NR_OPQ; q++) begin
      if (push[q]) begin
        check_cmd(q, int'(e.id), vs_exp[q], int'(e.sew),
                  (q == lane_seq_pkg::MASK_M) ? exp_mask_vl(int'(e.vl), int'(e.sew)) : lvl,
                  lvs);
      end
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic apply_entry(input int i);
    entry_t e;
    e = tbl[i];
    lane_id      = e.lane;
    pe_req       = build_req(i, e);
    pe_req_valid = 1'b1;
    if (e.hold_rdy != 0) begin
      rdy_left      = int'(e.hold_rdy);
      operand_ready = '0;
    end
    if (e.hold_run != 0) begin
      run_left = int'(e.hold_run);
      running  = lane_seq_pkg::vinsn_mask_t'(1) << e.id;
    end
    expect_eq("pe_req_ready_o", 32'(pe_req_ready), 1);
    step();
    pe_req_valid = 1'b0;

    if (e.blk) begin
      // The request now sits in the fall-through register
      expect_eq("pe_req_ready_o", 32'(pe_req_ready), 0);
      expect_eq("vfu_op_valid_o", 32'(vfu_op_valid), 0);
      while (!vfu_op_valid) begin
        step();
      end
      expect_eq("cycles left with operand ready low", 32'(rdy_left), 0);
      expect_eq("cycles left with running bit high", 32'(run_left), 0);
    end

    if (exp_lane_vl(int'(e.vl), int'(e.lane)) == 0) begin
      expect_eq("vfu_op_valid_o", 32'(vfu_op_valid), 0);
      expect_eq("operand_cmd_valid_o", 32'(cmd_valid), 0);
      expect_eq("pe_vinsn_done_o", 32'(done_o), 32'(1) << e.id);
    end else begin
      check_issue(i, e);
    end
    step();
  endtask

  task automatic run_done_phase();
    lane_seq_pkg::vinsn_mask_t prev_alu;
    lane_seq_pkg::vinsn_mask_t prev_mfpu;
    prev_alu  = '0;
    prev_mfpu = '0;
    repeat (RAND_CYCLES) begin
      step();
      expect_eq("pe_vinsn_done_o", 32'(done_o), 32'(prev_alu | prev_mfpu));
      expect_eq("alu_done_o", 32'(alu_done), 32'(|prev_alu));
      expect_eq("mfpu_done_o", 32'(mfpu_done), 32'(|prev_mfpu));
      draw_mask(prev_alu);
      draw_mask(prev_mfpu);
      alu_vinsn_done  = prev_alu;
      mfpu_vinsn_done = prev_mfpu;
    end
  endtask

  initial begin
    rst_n           = 1'b0;
    lane_id         = '0;
    pe_req          = '0;
    pe_req_valid    = 1'b0;
    running         = '0;
    operand_ready   = '1;
    alu_vinsn_done  = '0;
    mfpu_vinsn_done = '0;
    rdy_left        = 0;
    run_left        = 0;
    lfsr            = LFSR_SEED;

    // lane id vfu vm sw u1 u2 ud sew vl vstart hold_rdy hold_run blk
    tbl[0]  = make_entry(0, 0, 0, 1, 0, 1, 1, 0, 2, 10, 5, 0, 0, 0);
    tbl[1]  = make_entry(1, 1, 0, 1, 0, 1, 0, 0, 1, 10, 5, 0, 0, 0);
    tbl[2]  = make_entry(2, 2, 0, 0, 0, 0, 1, 0, 0, 10, 6, 0, 0, 0);
    tbl[3]  = make_entry(3, 3, 0, 1, 0, 1, 1, 0, 3, 10, 3, 0, 0, 0);
    tbl[4]  = make_entry(1, 4, 1, 0, 1, 1, 1, 1, 1, 100, 0, 0, 0, 0);
    tbl[5]  = make_entry(2, 5, 1, 1, 0, 0, 1, 1, 2, 64, 0, 4, 0, 0);
    tbl[6]  = make_entry(2, 6, 1, 1, 0, 1, 1, 1, 2, 64, 0, 0, 0, 1);
    tbl[7]  = make_entry(3, 7, 0, 0, 0, 1, 1, 0, 0, 256, 0, 5, 0, 0);
    tbl[8]  = make_entry(0, 0, 0, 1, 0, 1, 0, 0, 0, 40, 0, 0, 0, 1);
    tbl[9]  = make_entry(3, 1, 0, 1, 0, 1, 1, 0, 2, 2, 0, 0, 0, 0);
    tbl[10] = make_entry(1, 2, 1, 1, 0, 1, 1, 1, 3, 17, 0, 0, 5, 0);
    tbl[11] = make_entry(0, 2, 0, 1, 0, 1, 1, 0, 2, 17, 0, 0, 0, 1);

    repeat (RESET_CYCLES) @(negedge clk);
    expect_eq("pe_req_ready_o in reset", 32'(pe_req_ready), 1);
    expect_eq("vfu_op_valid_o in reset", 32'(vfu_op_valid), 0);
    expect_eq("operand_cmd_valid_o in reset", 32'(cmd_valid), 0);
    expect_eq("pe_vinsn_done_o in reset", 32'(done_o), 0);
    expect_eq("alu_done_o in reset", 32'(alu_done), 0);
    expect_eq("mfpu_done_o in reset", 32'(mfpu_done), 0);
    rst_n = 1'b1;
    step();

    for (int i = 0; i < N_ENTRIES; i++) begin
      apply_entry(i);
    end
    run_done_phase();

    $display("*** PASSED ***");
    $finish;
  end

  // Ends a run that stalls on a missing issue
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog timeout: the test sequence did not finish in time");
    $display("*** FAILED ***");
    $fatal(1, "Watchdog expired");
  end

endmodule

`default_nettype wire

// File: lane_sequencer.f
source/lane_seq_pkg.sv
source/req_fall_through_reg.sv
source/operand_cmd_regs.sv
source/lane_vl_split.sv
source/lane_dispatch.sv
source/lane_sequencer.sv
bench/tb_lane_sequencer.sv

// File: source/lane_dispatch.sv
`timescale 1ns/1ns
`default_nettype none

module lane_dispatch (
  input  wire                                                  clk_i,
  input  wire                                                  rst_ni,
  // Request presented by the fall-through register
  input  wire lane_seq_pkg::pe_req_t                           req_i,
  input  wire                                                  req_valid_i,
  output logic                                                 req_ready_o,
  input  wire lane_seq_pkg::lane_len_t                         len_i,
  // Operand command registers
  input  wire [lane_seq_pkg::NR_OPQ-1:0]                       cmd_valid_i,
  output lane_seq_pkg::operand_cmd_t [lane_seq_pkg::NR_OPQ-1:0] cmd_o,
  output logic [lane_seq_pkg::NR_OPQ-1:0]                      cmd_push_o,
  // Functional units
  output lane_seq_pkg::vfu_op_t                                vfu_op_o,
  output logic                                                 vfu_op_valid_o,
  // Instruction tracking
  input  wire lane_seq_pkg::vinsn_mask_t                       pe_vinsn_running_i,
  input  wire lane_seq_pkg::vinsn_mask_t                       alu_vinsn_done_i,
  input  wire lane_seq_pkg::vinsn_mask_t                       mfpu_vinsn_done_i,
  output lane_seq_pkg::vinsn_mask_t                            pe_vinsn_done_o,
  output logic                                                 alu_done_o,
  output logic                                                 mfpu_done_o
);

  function automatic lane_seq_pkg::operand_cmd_t make_cmd(
    input lane_seq_pkg::vid_t  id,
    input lane_seq_pkg::vreg_t vs,
    input lane_seq_pkg::sew_e  eew,
    input lane_seq_pkg::vlen_t vl,
    input lane_seq_pkg::vlen_t vstart
  );
    return '{id: id, vs: vs, eew: eew, vl: vl, vstart: vstart};
  endfunction

  lane_seq_pkg::vinsn_mask_t        running_live;
  lane_seq_pkg::vinsn_mask_t        running_d;
  lane_seq_pkg::vinsn_mask_t        running_q;
  lane_seq_pkg::vinsn_mask_t        done_d;
  lane_seq_pkg::vinsn_mask_t        done_q;
  lane_seq_pkg::vfu_op_t            vfu_op_d;
  logic [lane_seq_pkg::NR_OPQ-1:0]  want_push;
  logic                             queues_busy;
  logic                             issue;
  logic                             fire;
  lane_seq_pkg::vreg_t              mfpu_b_vs;
  lane_seq_pkg::vreg_t              mfpu_c_vs;
  logic                             mfpu_b_use;
  logic                             mfpu_c_use;

  ////////////////////////////////////////
  // Readiness
  ////////////////////////////////////////

  // Bits stay set only while the main sequencer still reports them
  assign running_live = running_q & pe_vinsn_running_i;

  // The last command for a queue must be taken before a new one goes in
  always_comb begin
    if (req_i.vfu == lane_seq_pkg::VFU_ALU) begin
      queues_busy = cmd_valid_i[lane_seq_pkg::ALU_A] |
                    cmd_valid_i[lane_seq_pkg::ALU_B] |
                    cmd_valid_i[lane_seq_pkg::MASK_M];
    end else begin
      queues_busy = cmd_valid_i[lane_seq_pkg::MFPU_A] |
                    cmd_valid_i[lane_seq_pkg::MFPU_B] |
                    cmd_valid_i[lane_seq_pkg::MFPU_C] |
                    cmd_valid_i[lane_seq_pkg::MASK_M];
    end
  end

  assign req_ready_o = !queues_busy && !running_live[req_i.id];
  assign issue       = req_valid_i && req_ready_o;
  // A lane without elements has nothing to run
  assign fire        = issue && (len_i.lane_vl != '0);

  ////////////////////////////////////////
  // Operation and operand commands
  ////////////////////////////////////////

  // Multiply-add forms read the destination through the B queue
  assign mfpu_b_vs  = req_i.swap_vs2_vd ? req_i.vd : req_i.vs2;
  assign mfpu_c_vs  = req_i.swap_vs2_vd ? req_i.vs2 : req_i.vd;
  assign mfpu_b_use = req_i.swap_vs2_vd ? req_i.use_vd_op : req_i.use_vs2;
  assign mfpu_c_use = req_i.swap_vs2_vd ? req_i.use_vs2 : req_i.use_vd_op;

  always_comb begin
    vfu_op_d = '{id: req_i.id, op: req_i.op, vfu: req_i.vfu, vm: req_i.vm, vd: req_i.vd,
                 sew: req_i.sew, vl: len_i.lane_vl, vstart: len_i.lane_vstart};
    cmd_o     = '0;
    want_push = '0;

    // Mask operand shared by both units
    cmd_o[lane_seq_pkg::MASK_M] =
      make_cmd(req_i.id, '0, req_i.sew, len_i.mask_vl, len_i.lane_vstart);
    want_push[lane_seq_pkg::MASK_M] = !req_i.vm;

    if (req_i.vfu == lane_seq_pkg::VFU_ALU) begin
      cmd_o[lane_seq_pkg::ALU_A] =
        make_cmd(req_i.id, req_i.vs1, req_i.sew, len_i.lane_vl, len_i.lane_vstart);
      cmd_o[lane_seq_pkg::ALU_B] =
        make_cmd(req_i.id, req_i.vs2, req_i.sew, len_i.lane_vl, len_i.lane_vstart);
      want_push[lane_seq_pkg::ALU_A] = req_i.use_vs1;
      want_push[lane_seq_pkg::ALU_B] = req_i.use_vs2;
    end else begin
      cmd_o[lane_seq_pkg::MFPU_A] =
        make_cmd(req_i.id, req_i.vs1, req_i.sew, len_i.lane_vl, len_i.lane_vstart);
      cmd_o[lane_seq_pkg::MFPU_B] =
        make_cmd(req_i.id, mfpu_b_vs, req_i.sew, len_i.lane_vl, len_i.lane_vstart);
      cmd_o[lane_seq_pkg::MFPU_C] =
        make_cmd(req_i.id, mfpu_c_vs, req_i.sew, len_i.lane_vl, len_i.lane_vstart);
      want_push[lane_seq_pkg::MFPU_A] = req_i.use_vs1;
      want_push[lane_seq_pkg::MFPU_B] = mfpu_b_use;
      want_push[lane_seq_pkg::MFPU_C] = mfpu_c_use;
    end

    cmd_push_o = fire ? want_push : '0;
  end

  ////////////////////////////////////////
  // Running and done tracking
  ////////////////////////////////////////

  always_comb begin
    running_d = running_live;
    done_d    = alu_vinsn_done_i | mfpu_vinsn_done_i;
    if (fire) begin
      running_d[req_i.id] = 1'b1;
    end else if (issue) begin
      // An empty lane reports completion right away
      done_d[req_i.id] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q      <= '0;
      done_q         <= '0;
      vfu_op_valid_o <= 1'b0;
      alu_done_o     <= 1'b0;
      mfpu_done_o    <= 1'b0;
    end else begin
      running_q      <= running_d;
      done_q         <= done_d;
      vfu_op_valid_o <= fire;
      alu_done_o     <= |alu_vinsn_done_i;
      mfpu_done_o    <= |mfpu_vinsn_done_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fire) begin
      vfu_op_o <= vfu_op_d;
    end
  end

  assign pe_vinsn_done_o = done_q;

endmodule

`default_nettype wire

// File: source/lane_seq_pkg.sv
`default_nettype none

package lane_seq_pkg;

  ////////////////////////////////////////
  // Lane configuration
  ////////////////////////////////////////

  localparam int unsigned NR_LANES = 4;
  localparam int unsigned NR_VINSN = 8;
  localparam int unsigned NR_OPQ = 6;
  localparam int unsigned MASK_BITS_PER_LANE_WORD = 8;

  // Field widths derived from the configuration
  localparam int unsigned LANE_ID_W = $clog2(NR_LANES);
  localparam int unsigned VID_W = $clog2(NR_VINSN);
  localparam int unsigned VREG_W = 5;
  localparam int unsigned VLEN_W = 16;
  localparam int unsigned VOP_W = 6;

  typedef logic [LANE_ID_W-1:0] lane_id_t;
  typedef logic [VID_W-1:0]     vid_t;
  typedef logic [NR_VINSN-1:0]  vinsn_mask_t;
  typedef logic [VREG_W-1:0]    vreg_t;
  typedef logic [VLEN_W-1:0]    vlen_t;
  typedef logic [VOP_W-1:0]     vop_t;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } sew_e;

  typedef enum logic {
    VFU_ALU  = 1'b0,
    VFU_MFPU = 1'b1
  } vfu_e;

  // Index of each operand queue in the command vectors
  typedef enum logic [2:0] {
    ALU_A  = 3'd0,
    ALU_B  = 3'd1,
    MFPU_A = 3'd2,
    MFPU_B = 3'd3,
    MFPU_C = 3'd4,
    MASK_M = 3'd5
  } opq_e;

  ////////////////////////////////////////
  // Interface records
  ////////////////////////////////////////

  // Request from the main sequencer
  typedef struct packed {
    vid_t  id;
    vop_t  op;
    vfu_e  vfu;
    logic  vm;
    vreg_t vs1;
    vreg_t vs2;
    vreg_t vd;
    logic  use_vs1;
    logic  use_vs2;
    logic  use_vd_op;
    logic  swap_vs2_vd;
    sew_e  sew;
    vlen_t vl;
    vlen_t vstart;
  } pe_req_t;

  // Operation handed to the lane's functional units with the lengths already split
  typedef struct packed {
    vid_t  id;
    vop_t  op;
    vfu_e  vfu;
    logic  vm;
    vreg_t vd;
    sew_e  sew;
    vlen_t vl;
    vlen_t vstart;
  } vfu_op_t;

  // Per-lane lengths derived from a request
  typedef struct packed {
    vlen_t lane_vl;
    vlen_t lane_vstart;
    vlen_t mask_vl;
  } lane_len_t;

  // Command for one operand queue
  typedef struct packed {
    vid_t  id;
    vreg_t vs;
    sew_e  eew;
    vlen_t vl;
    vlen_t vstart;
  } operand_cmd_t;

endpackage

`default_nettype wire

// File: source/lane_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module lane_sequencer (
  input  wire                                                  clk_i,
  input  wire                                                  rst_ni,
  input  wire lane_seq_pkg::lane_id_t                          lane_id_i,
  // Main sequencer
  input  wire lane_seq_pkg::pe_req_t                           pe_req_i,
  input  wire                                                  pe_req_valid_i,
  output logic                                                 pe_req_ready_o,
  input  wire lane_seq_pkg::vinsn_mask_t                       pe_vinsn_running_i,
  output lane_seq_pkg::vinsn_mask_t                            pe_vinsn_done_o,
  // Register-file reader
  output lane_seq_pkg::operand_cmd_t [lane_seq_pkg::NR_OPQ-1:0] operand_cmd_o,
  output logic [lane_seq_pkg::NR_OPQ-1:0]                      operand_cmd_valid_o,
  input  wire [lane_seq_pkg::NR_OPQ-1:0]                       operand_cmd_ready_i,
  // Functional units
  output lane_seq_pkg::vfu_op_t                                vfu_op_o,
  output logic                                                 vfu_op_valid_o,
  input  wire lane_seq_pkg::vinsn_mask_t                       alu_vinsn_done_i,
  input  wire lane_seq_pkg::vinsn_mask_t                       mfpu_vinsn_done_i,
  output logic                                                 alu_done_o,
  output logic                                                 mfpu_done_o
);

  lane_seq_pkg::pe_req_t                             req;
  logic                                              req_valid;
  logic                                              req_ready;
  lane_seq_pkg::lane_len_t                           len;
  lane_seq_pkg::operand_cmd_t [lane_seq_pkg::NR_OPQ-1:0] cmd;
  logic [lane_seq_pkg::NR_OPQ-1:0]                   cmd_push;

  req_fall_through_reg i_req_reg (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .data_i  (pe_req_i),
    .valid_i (pe_req_valid_i),
    .ready_o (pe_req_ready_o),
    .data_o  (req),
    .valid_o (req_valid),
    .ready_i (req_ready)
  );

  lane_vl_split i_vl_split (
    .req_i     (req),
    .lane_id_i (lane_id_i),
    .len_o     (len)
  );

  lane_dispatch i_dispatch (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .req_i              (req),
    .req_valid_i        (req_valid),
    .req_ready_o        (req_ready),
    .len_i              (len),
    .cmd_valid_i        (operand_cmd_valid_o),
    .cmd_o              (cmd),
    .cmd_push_o         (cmd_push),
    .vfu_op_o           (vfu_op_o),
    .vfu_op_valid_o     (vfu_op_valid_o),
    .pe_vinsn_running_i (pe_vinsn_running_i),
    .alu_vinsn_done_i   (alu_vinsn_done_i),
    .mfpu_vinsn_done_i  (mfpu_vinsn_done_i),
    .pe_vinsn_done_o    (pe_vinsn_done_o),
    .alu_done_o         (alu_done_o),
    .mfpu_done_o        (mfpu_done_o)
  );

  operand_cmd_regs i_cmd_regs (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .cmd_i   (cmd),
    .push_i  (cmd_push),
    .cmd_o   (operand_cmd_o),
    .valid_o (operand_cmd_valid_o),
    .ready_i (operand_cmd_ready_i)
  );

endmodule

`default_nettype wire

// File: source/lane_vl_split.sv
`timescale 1ns/1ns
`default_nettype none

module lane_vl_split (
  input  wire lane_seq_pkg::pe_req_t    req_i,
  input  wire lane_seq_pkg::lane_id_t   lane_id_i,
  output lane_seq_pkg::lane_len_t       len_o
);

  localparam int unsigned MASK_SPAN = lane_seq_pkg::NR_LANES *
                                      lane_seq_pkg::MASK_BITS_PER_LANE_WORD;

  lane_seq_pkg::lane_id_t vl_rem;
  lane_seq_pkg::lane_id_t vstart_rem;
  logic [31:0]            mask_words;
  logic [31:0]            mask_cover;

  // Lane count is a power of two, so the remainder is the low index bits
  assign vl_rem     = req_i.vl[lane_seq_pkg::LANE_ID_W-1:0];
  assign vstart_rem = req_i.vstart[lane_seq_pkg::LANE_ID_W-1:0];

  always_comb begin
    // Elements are dealt round robin so the first lanes take the leftover
    len_o.lane_vl = lane_seq_pkg::vlen_t'(req_i.vl / lane_seq_pkg::NR_LANES);
    if (lane_id_i < vl_rem) begin
      len_o.lane_vl = len_o.lane_vl + lane_seq_pkg::vlen_t'(1);
    end

    len_o.lane_vstart = lane_seq_pkg::vlen_t'(req_i.vstart / lane_seq_pkg::NR_LANES);
    if (lane_id_i < vstart_rem) begin
      len_o.lane_vstart = len_o.lane_vstart - lane_seq_pkg::vlen_t'(1);
    end

    // Mask words come from every lane, so round up over the whole vector
    mask_words = (32'(req_i.vl) / MASK_SPAN) >> req_i.sew;
    mask_cover = (mask_words << req_i.sew) * MASK_SPAN;
    if (mask_cover != 32'(req_i.vl)) begin
      mask_words = mask_words + 32'd1;
    end
    len_o.mask_vl = lane_seq_pkg::vlen_t'(mask_words);
  end

endmodule

`default_nettype wire

// File: source/operand_cmd_regs.sv
`timescale 1ns/1ns
`default_nettype none

module operand_cmd_regs (
  input  wire                                                  clk_i,
  input  wire                                                  rst_ni,
  // New commands from the dispatch logic
  input  wire lane_seq_pkg::operand_cmd_t [lane_seq_pkg::NR_OPQ-1:0] cmd_i,
  input  wire [lane_seq_pkg::NR_OPQ-1:0]                       push_i,
  // Towards the register-file reader
  output lane_seq_pkg::operand_cmd_t [lane_seq_pkg::NR_OPQ-1:0] cmd_o,
  output logic [lane_seq_pkg::NR_OPQ-1:0]                      valid_o,
  input  wire [lane_seq_pkg::NR_OPQ-1:0]                       ready_i
);

  logic [lane_seq_pkg::NR_OPQ-1:0] valid_d;

  // A push in the same cycle as the ready replaces the old command
  assign valid_d = (valid_o & ~ready_i) | push_i;

  for (genvar q = 0; q < lane_seq_pkg::NR_OPQ; q++) begin : g_queue

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        valid_o[q] <= 1'b0;
      end else begin
        valid_o[q] <= valid_d[q];
      end
    end

    always_ff @(posedge clk_i) begin
      if (push_i[q]) begin
        cmd_o[q] <= cmd_i[q];
      end
    end

  end

endmodule

`default_nettype wire

// File: source/req_fall_through_reg.sv
`timescale 1ns/1ns
`default_nettype none

module req_fall_through_reg (
  input  wire                   clk_i,
  input  wire                   rst_ni,
  // Producer side
  input  wire lane_seq_pkg::pe_req_t data_i,
  input  wire                   valid_i,
  output logic                  ready_o,
  // Consumer side
  output lane_seq_pkg::pe_req_t data_o,
  output logic                  valid_o,
  input  wire                   ready_i
);

  logic                  full_q;
  logic                  capture;
  lane_seq_pkg::pe_req_t data_q;

  // An empty register lets the request pass in the same cycle
  assign ready_o = !full_q;
  assign valid_o = full_q | valid_i;
  assign data_o  = full_q ? data_q : data_i;

  // Only keep a copy when the consumer refuses the passing request
  assign capture = !full_q && valid_i && !ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (full_q) begin
      if (ready_i) begin
        full_q <= 1'b0;
      end
    end else if (capture) begin
      full_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      data_q <= data_i;
    end
  end

endmodule

`default_nettype wire
